//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rob_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/rob_commit.sv
`timescale 1ns/1ps

module rob_commit (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                   slot_valid,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                   slot_ready,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                   slot_exc,
    input  rob_pkg::cause_t [rob_pkg::ROB_DEPTH-1:0]        slot_cause,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                   slot_mret,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                   slot_reg_write,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                   slot_mem_write,
    input  logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::RD_W-1:0] slot_rd,
    input  logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::FUNCT3_W-1:0] slot_funct3,
    input  logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::XLEN-1:0] slot_pc,
    input  logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::XLEN-1:0] slot_value,
    output logic [rob_pkg::ROB_DEPTH-1:0]                   retire,
    output logic                                            flush_all,
    output logic                                            retire_pulse,
    output rob_pkg::tag_t                                   head_tag,
    output logic                                            commit_valid,
    output rob_pkg::tag_t                                   commit_tag,
    output logic [rob_pkg::XLEN-1:0]                        commit_pc,
    output logic [rob_pkg::XLEN-1:0]                        commit_value,
    output logic [rob_pkg::RD_W-1:0]                        commit_rd,
    output logic [rob_pkg::FUNCT3_W-1:0]                    commit_funct3,
    output logic                                            commit_reg_write,
    output logic                                            commit_mem_write,
    output logic                                            mret_sig,
    output logic                                            exception_sig,
    output rob_pkg::cause_t                                 exception_cause,
    output logic [rob_pkg::XLEN-1:0]                        epc
);
    import rob_pkg::*;

    tag_t head;
    logic head_done;                                // Head valid and ready
    logic do_commit;
    logic do_mret;

    assign head_tag     = head;
    assign head_done    = slot_valid[head] & slot_ready[head];
    assign flush_all    = head_done & slot_exc[head];
    assign retire_pulse = head_done & ~slot_exc[head];
    assign do_mret      = retire_pulse & slot_mret[head];
    assign do_commit    = retire_pulse & ~slot_mret[head];

    always_comb begin
        retire = '0;
        retire[head] = retire_pulse;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head             <= '0;
            commit_valid     <= 1'b0;
            commit_reg_write <= 1'b0;
            commit_mem_write <= 1'b0;
            mret_sig         <= 1'b0;
            exception_sig    <= 1'b0;
        end else begin
            commit_valid     <= do_commit;
            commit_reg_write <= do_commit & slot_reg_write[head];   // Only on a real retire
            commit_mem_write <= do_commit & slot_mem_write[head];
            mret_sig         <= do_mret;
            exception_sig    <= flush_all;
            if (flush_all) begin
                head <= '0;
            end else if (retire_pulse) begin
                head <= head + tag_t'(1);
            end
        end
    end

    // Result payload, qualified by the strobes above
    always_ff @(posedge clk) begin
        commit_tag      <= head;
        commit_pc       <= slot_pc[head];
        commit_value    <= slot_value[head];
        commit_rd       <= slot_rd[head];
        commit_funct3   <= slot_funct3[head];
        exception_cause <= slot_cause[head];
        epc             <= slot_pc[head];
    end

    // A trap leaves every slot empty
    a_trap_empties_slots : assert property (
        @(posedge clk) disable iff (rst) exception_sig |-> (slot_valid == '0)
    );

endmodule

//--- hdl/rob_dispatch.sv
`timescale 1ns/1ps

module rob_dispatch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          disp_valid,
    input  logic                          br_valid,
    input  logic                          br_mispredict,
    input  rob_pkg::tag_t                 br_tag,
    input  logic                          retire_pulse,
    input  logic                          flush_all,
    output logic [rob_pkg::ROB_DEPTH-1:0] alloc,
    output logic [rob_pkg::ROB_DEPTH-1:0] squash,
    output rob_pkg::tag_t                 disp_tag,
    output logic                          rob_full
);
    import rob_pkg::*;

    tag_t           tail;
    tag_t           head;                           // Shadow of the commit head
    logic [TAG_W:0] count;                          // Occupied entries, 0 to ROB_DEPTH
    logic           mispredict;
    logic           accept;
    tag_t           br_age;                         // Branch distance from head

    assign mispredict = br_valid & br_mispredict;
    assign rob_full   = (count == (TAG_W+1)'(ROB_DEPTH));
    assign accept     = disp_valid & ~rob_full & ~mispredict & ~flush_all;
    assign disp_tag   = tail;
    assign br_age     = br_tag - head;

    always_comb begin
        tag_t age;
        alloc  = '0;
        squash = '0;
        if (accept) begin
            alloc[tail] = 1'b1;
        end
        // Younger than the branch and still inside the occupied window
        for (int i = 0; i < ROB_DEPTH; i++) begin
            age       = tag_t'(i) - head;
            squash[i] = mispredict && (age > br_age) && ({1'b0, age} < count);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_all) begin
            tail  <= '0;
            head  <= '0;
            count <= '0;
        end else begin
            if (retire_pulse) begin
                head <= head + tag_t'(1);
            end
            if (mispredict) begin
                tail  <= br_tag + tag_t'(1);        // Refill right after the branch
                count <= {1'b0, br_age} + (TAG_W+1)'(1) - (TAG_W+1)'(retire_pulse);
            end else begin
                if (accept) begin
                    tail <= tail + tag_t'(1);
                end
                count <= count + (TAG_W+1)'(accept) - (TAG_W+1)'(retire_pulse);
            end
        end
    end

    // Occupancy stays in range and matches the pointer distance
    a_count_tracks_pointers : assert property (
        @(posedge clk) disable iff (rst)
        (count <= (TAG_W+1)'(ROB_DEPTH)) && (tail - head == tag_t'(count))
    );

endmodule

//--- hdl/rob_pkg.sv
package rob_pkg;

    // Buffer geometry
    localparam int ROB_DEPTH = 16;
    localparam int TAG_W     = 4;                   // log2 of ROB_DEPTH
    localparam int NUM_WB    = 3;                   // 0 ALU, 1 mul/div, 2 load/store
    localparam int XLEN      = 32;

    // Instruction word fields used at retire
    localparam int RD_LSB     = 7;
    localparam int RD_W       = 5;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_W   = 3;

    typedef logic [TAG_W-1:0] tag_t;                // Entry index, also the tag
    typedef logic [1:0]       cause_t;

    // Exception cause codes
    localparam cause_t CAUSE_NONE    = 2'd0;
    localparam cause_t CAUSE_DIV     = 2'd1;
    localparam cause_t CAUSE_LOAD    = 2'd2;
    localparam cause_t CAUSE_ILLEGAL = 2'd3;

    // Cause raised by each writeback port, none means the port cannot trap
    localparam cause_t WB_CAUSE [NUM_WB] = '{CAUSE_NONE, CAUSE_DIV, CAUSE_LOAD};

endpackage

//--- hdl/rob_slot.sv
`timescale 1ns/1ps

module rob_slot #(
    parameter rob_pkg::tag_t SLOT_IDX = '0
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        alloc,
    input  logic                                        squash,
    input  logic                                        retire,
    input  logic                                        flush_all,
    input  logic [rob_pkg::XLEN-1:0]                    disp_inst,
    input  logic [rob_pkg::XLEN-1:0]                    disp_pc,
    input  logic                                        disp_reg_write,
    input  logic                                        disp_mem_write,
    input  logic                                        disp_mret,
    input  logic                                        disp_exception,
    input  logic [rob_pkg::NUM_WB-1:0]                  wb_valid,
    input  rob_pkg::tag_t [rob_pkg::NUM_WB-1:0]         wb_tag,
    input  logic [rob_pkg::NUM_WB-1:0][rob_pkg::XLEN-1:0] wb_value,
    input  logic [rob_pkg::NUM_WB-1:0]                  wb_exc,
    input  logic                                        br_valid,
    input  rob_pkg::tag_t                               br_tag,
    input  logic [rob_pkg::XLEN-1:0]                    br_target,
    output logic                                        slot_valid,
    output logic                                        slot_ready,
    output logic                                        slot_exc,
    output logic                                        slot_mret,
    output logic                                        slot_reg_write,
    output logic                                        slot_mem_write,
    output rob_pkg::cause_t                             slot_cause,
    output logic [rob_pkg::RD_W-1:0]                    slot_rd,
    output logic [rob_pkg::FUNCT3_W-1:0]                slot_funct3,
    output logic [rob_pkg::XLEN-1:0]                    slot_pc,
    output logic [rob_pkg::XLEN-1:0]                    slot_value
);
    import rob_pkg::*;

    logic [NUM_WB-1:0] wb_hit;
    logic              br_hit;

    always_comb begin
        for (int p = 0; p < NUM_WB; p++) begin
            wb_hit[p] = wb_valid[p] && (wb_tag[p] == SLOT_IDX);
        end
    end

    assign br_hit = br_valid && (br_tag == SLOT_IDX);

    always_ff @(posedge clk) begin
        if (rst || flush_all || squash || retire) begin
            slot_valid <= 1'b0;
            slot_ready <= 1'b0;
            slot_exc   <= 1'b0;
        end else if (slot_valid) begin
            for (int p = 0; p < NUM_WB; p++) begin
                if (wb_hit[p]) begin
                    slot_ready <= 1'b1;
                    slot_value <= wb_value[p];
                    if (wb_exc[p] && WB_CAUSE[p] != CAUSE_NONE) begin
                        slot_exc   <= 1'b1;
                        slot_cause <= WB_CAUSE[p];
                    end
                end
            end
            if (br_hit) begin
                slot_ready <= 1'b1;
                slot_value <= br_target;            // Resolved target as result
            end
        end else if (alloc) begin
            slot_valid     <= 1'b1;
            slot_ready     <= disp_exception | disp_mret;   // Nothing to wait for
            slot_exc       <= disp_exception;
            slot_cause     <= disp_exception ? CAUSE_ILLEGAL : CAUSE_NONE;
            slot_mret      <= disp_mret;
            slot_reg_write <= disp_reg_write;
            slot_mem_write <= disp_mem_write;
            slot_rd        <= disp_inst[RD_LSB +: RD_W];
            slot_funct3    <= disp_inst[FUNCT3_LSB +: FUNCT3_W];
            slot_pc        <= disp_pc;
            slot_value     <= '0;
        end
    end

    a_wb_to_live_slot : assert property (
        @(posedge clk) disable iff (rst) !slot_valid |-> (wb_hit == '0)
    );

endmodule

//--- hdl/rob_top.sv
`timescale 1ns/1ps

module rob_top (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          disp_valid,
    input  logic [rob_pkg::XLEN-1:0]                      disp_inst,
    input  logic [rob_pkg::XLEN-1:0]                      disp_pc,
    input  logic                                          disp_reg_write,
    input  logic                                          disp_mem_write,
    input  logic                                          disp_mret,
    input  logic                                          disp_exception,
    output rob_pkg::tag_t                                 disp_tag,
    output logic                                          rob_full,
    input  logic [rob_pkg::NUM_WB-1:0]                    wb_valid,
    input  rob_pkg::tag_t [rob_pkg::NUM_WB-1:0]           wb_tag,
    input  logic [rob_pkg::NUM_WB-1:0][rob_pkg::XLEN-1:0] wb_value,
    input  logic [rob_pkg::NUM_WB-1:0]                    wb_exc,
    input  logic                                          br_valid,
    input  rob_pkg::tag_t                                 br_tag,
    input  logic [rob_pkg::XLEN-1:0]                      br_target,
    input  logic                                          br_mispredict,
    output logic                                          commit_valid,
    output rob_pkg::tag_t                                 commit_tag,
    output logic [rob_pkg::XLEN-1:0]                      commit_pc,
    output logic [rob_pkg::XLEN-1:0]                      commit_value,
    output logic [rob_pkg::RD_W-1:0]                      commit_rd,
    output logic [rob_pkg::FUNCT3_W-1:0]                  commit_funct3,
    output logic                                          commit_reg_write,
    output logic                                          commit_mem_write,
    output logic                                          mret_sig,
    output logic                                          exception_sig,
    output rob_pkg::cause_t                               exception_cause,
    output logic [rob_pkg::XLEN-1:0]                      epc
);
    import rob_pkg::*;

    logic [ROB_DEPTH-1:0]               alloc;
    logic [ROB_DEPTH-1:0]               squash;
    logic [ROB_DEPTH-1:0]               retire;
    logic                               flush_all;
    logic                               retire_pulse;
    logic [ROB_DEPTH-1:0]               slot_valid;
    logic [ROB_DEPTH-1:0]               slot_ready;
    logic [ROB_DEPTH-1:0]               slot_exc;
    logic [ROB_DEPTH-1:0]               slot_mret;
    logic [ROB_DEPTH-1:0]               slot_reg_write;
    logic [ROB_DEPTH-1:0]               slot_mem_write;
    cause_t [ROB_DEPTH-1:0]             slot_cause;
    logic [ROB_DEPTH-1:0][RD_W-1:0]     slot_rd;
    logic [ROB_DEPTH-1:0][FUNCT3_W-1:0] slot_funct3;
    logic [ROB_DEPTH-1:0][XLEN-1:0]     slot_pc;
    logic [ROB_DEPTH-1:0][XLEN-1:0]     slot_value;

    rob_dispatch u_dispatch (
        .clk, .rst, .disp_valid, .br_valid, .br_mispredict, .br_tag,
        .retire_pulse, .flush_all, .alloc, .squash, .disp_tag, .rob_full
    );

    for (genvar i = 0; i < ROB_DEPTH; i++) begin : g_slot
        rob_slot #(.SLOT_IDX(tag_t'(i))) u_slot (
            .clk, .rst,
            .alloc          (alloc[i]),
            .squash         (squash[i]),
            .retire         (retire[i]),
            .flush_all,
            .disp_inst, .disp_pc, .disp_reg_write, .disp_mem_write,
            .disp_mret, .disp_exception,
            .wb_valid, .wb_tag, .wb_value, .wb_exc,
            .br_valid, .br_tag, .br_target,
            .slot_valid     (slot_valid[i]),
            .slot_ready     (slot_ready[i]),
            .slot_exc       (slot_exc[i]),
            .slot_mret      (slot_mret[i]),
            .slot_reg_write (slot_reg_write[i]),
            .slot_mem_write (slot_mem_write[i]),
            .slot_cause     (slot_cause[i]),
            .slot_rd        (slot_rd[i]),
            .slot_funct3    (slot_funct3[i]),
            .slot_pc        (slot_pc[i]),
            .slot_value     (slot_value[i])
        );
    end

    rob_commit u_commit (
        .clk, .rst,
        .slot_valid, .slot_ready, .slot_exc, .slot_cause, .slot_mret,
        .slot_reg_write, .slot_mem_write, .slot_rd, .slot_funct3, .slot_pc, .slot_value,
        .retire, .flush_all, .retire_pulse, .head_tag (),
        .commit_valid, .commit_tag, .commit_pc, .commit_value, .commit_rd,
        .commit_funct3, .commit_reg_write, .commit_mem_write,
        .mret_sig, .exception_sig, .exception_cause, .epc
    );

endmodule

//--- src.f
hdl/rob_pkg.sv
hdl/rob_dispatch.sv
hdl/rob_slot.sv
hdl/rob_commit.sv
hdl/rob_top.sv
verif/rob_clkgen.sv
verif/rob_tb.sv

//--- verif/rob_clkgen.sv
`timescale 1ns/1ps

module rob_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                      // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- verif/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;
    import rob_pkg::*;

    localparam logic [2:0] ACT_IDLE = 3'd0, ACT_DISP = 3'd1, ACT_WB = 3'd2;
    localparam logic [2:0] ACT_BR = 3'd3, ACT_FULL = 3'd4, ACT_SYNC = 3'd5;
    localparam logic [1:0] EV_COMMIT = 2'd0, EV_MRET = 2'd1, EV_EXC = 2'd2;

    typedef struct packed {
        logic [2:0]  act;
        logic [7:0]  group;                         // Rows of one group are shuffled
        logic [7:0]  test;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        rw;
        logic        mw;
        logic        mret;
        logic        exc;
        logic [1:0]  port;
        tag_t        tag;
        logic [31:0] value;
        logic        mispredict;
        logic        chk_tag;
        tag_t        exp_tag;
    } row_t;

    typedef struct packed {
        logic [1:0]  kind;
        tag_t        tag;
        logic [31:0] pc;
        logic [31:0] value;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        rw;
        logic        mw;
        cause_t      cause;
    } event_t;

    logic clk, rst;
    logic disp_valid, disp_reg_write, disp_mem_write, disp_mret, disp_exception;
    logic [XLEN-1:0] disp_inst, disp_pc;
    tag_t disp_tag;
    logic rob_full;
    logic [NUM_WB-1:0] wb_valid, wb_exc;
    tag_t [NUM_WB-1:0] wb_tag;
    logic [NUM_WB-1:0][XLEN-1:0] wb_value;
    logic br_valid, br_mispredict;
    tag_t br_tag;
    logic [XLEN-1:0] br_target;
    logic commit_valid, commit_reg_write, commit_mem_write, mret_sig, exception_sig;
    tag_t commit_tag;
    logic [XLEN-1:0] commit_pc, commit_value, epc;
    logic [RD_W-1:0] commit_rd;
    logic [FUNCT3_W-1:0] commit_funct3;
    cause_t exception_cause;

    row_t   rows[$];
    event_t exp_q[$];                               // Predicted retire events, in order
    event_t m_ent[ROB_DEPTH];
    logic   m_valid[ROB_DEPTH];
    logic   m_ready[ROB_DEPTH];
    tag_t   m_head, m_tail;
    int     pc_seq = 0;
    int     err_count = 0;
    int     errs_at_start = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    event_t seen;
    logic [1:0] got_kind;

    rob_clkgen u_clkgen (.clk, .rst);

    rob_top DUT (.*);

    task automatic check_commit(tag_t tag, logic [XLEN-1:0] pc, logic [XLEN-1:0] value,
                                logic [RD_W-1:0] rd, logic [FUNCT3_W-1:0] f3,
                                logic rw, logic mw, event_t e);
        if (tag !== e.tag || pc !== e.pc || value !== e.value || rd !== e.rd
                || f3 !== e.f3 || rw !== e.rw || mw !== e.mw) begin
            $write("ERR %0t: commit tag %0d pc %h val %h rd %0d f3 %0d rw %b mw %b",
                $time, tag, pc, value, rd, f3, rw, mw);
            $display(", exp %0d %h %h %0d %0d %b %b",
                e.tag, e.pc, e.value, e.rd, e.f3, e.rw, e.mw);
            err_count++;
        end
    endtask

    task automatic check_exception(cause_t cause, logic [XLEN-1:0] pc, logic cv, event_t e);
        if (cause !== e.cause || pc !== e.pc || cv !== 1'b0) begin
            $display("ERR %0t: exception cause %0d epc %h cv %b, exp cause %0d epc %h",
                $time, cause, pc, cv, e.cause, e.pc);
            err_count++;
        end
    endtask

    task automatic check_mret(logic cv, event_t e);
        if (cv !== 1'b0) begin
            $display("ERR %0t: mret of tag %0d came with commit_valid high", $time, e.tag);
            err_count++;
        end
    endtask

    task automatic check_tag(tag_t got, tag_t exp, string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    // Table building
    task automatic dispatch_row(int test, int rd, int f3, bit rw, bit mw, bit mret, bit exc,
                                int exp_tag);
        row_t r;
        r         = '0;
        r.act     = ACT_DISP;
        r.test    = 8'(test);
        r.pc      = 32'h8000_0000 + 32'(4 * pc_seq);
        r.rd      = 5'(rd);
        r.f3      = 3'(f3);
        r.rw      = rw;
        r.mw      = mw;
        r.mret    = mret;
        r.exc     = exc;
        r.chk_tag = (exp_tag >= 0);
        r.exp_tag = tag_t'(exp_tag);
        pc_seq++;
        rows.push_back(r);
    endtask

    task automatic writeback_row(int group, int port, int tag, logic [31:0] value, bit exc);
        row_t r;
        r       = '0;
        r.act   = ACT_WB;
        r.group = 8'(group);
        r.port  = 2'(port);
        r.tag   = tag_t'(tag);
        r.value = value;
        r.exc   = exc;
        rows.push_back(r);
    endtask

    task automatic branch_row(int tag, logic [31:0] target, bit mispredict);
        row_t r;
        r            = '0;
        r.act        = ACT_BR;
        r.tag        = tag_t'(tag);
        r.value      = target;
        r.mispredict = mispredict;
        rows.push_back(r);
    endtask

    task automatic full_probe_row();
        row_t r;
        r     = '0;
        r.act = ACT_FULL;
        rows.push_back(r);
    endtask

    task automatic sync_row(int test);             // Test 0 syncs without a report
        row_t r;
        r      = '0;
        r.act  = ACT_SYNC;
        r.test = 8'(test);
        rows.push_back(r);
    endtask

    task automatic build_table();
        for (int k = 0; k < 8; k++) begin           // In-order retirement
            dispatch_row(1, k + 1, k, k != 3, k == 3, 0, 0, k);
        end
        for (int k = 0; k < 8; k++) begin
            writeback_row(1, k % 3, k, 32'h1000_0000 + 32'(k * 32'h111), 0);
        end
        sync_row(1);
        for (int k = 0; k < 16; k++) begin          // Fill up
            dispatch_row(2, k + 1, 2, 1, 0, 0, 0, (8 + k) % 16);
        end
        full_probe_row();
        writeback_row(0, 0, 8, 32'h2222_0008, 0);
        dispatch_row(2, 20, 1, 1, 0, 0, 0, 8);
        full_probe_row();                           // Full again once accepted
        sync_row(2);
        writeback_row(0, 1, 9, 32'hdead_0009, 1);   // Divide trap at head
        sync_row(0);
        dispatch_row(4, 3, 0, 1, 0, 0, 0, 0);
        writeback_row(0, 0, 0, 32'h4444_0000, 0);
        sync_row(4);
        dispatch_row(3, 4, 0, 1, 0, 0, 0, 1);       // Mispredict at tag 2
        dispatch_row(3, 0, 1, 0, 0, 0, 0, 2);
        dispatch_row(3, 5, 0, 1, 0, 0, 0, 3);
        dispatch_row(3, 6, 2, 0, 1, 0, 0, 4);
        writeback_row(0, 0, 1, 32'h3333_0001, 0);
        writeback_row(0, 2, 4, 32'h3333_0004, 0);
        branch_row(2, 32'h8000_0400, 1);
        sync_row(0);
        dispatch_row(3, 7, 4, 1, 0, 0, 0, 3);
        writeback_row(0, 1, 3, 32'h3333_0003, 0);
        sync_row(3);
        dispatch_row(5, 8, 2, 1, 0, 0, 0, 4);       // Load trap
        dispatch_row(5, 9, 0, 1, 0, 0, 0, 5);
        dispatch_row(5, 10, 0, 1, 0, 0, 0, 6);
        writeback_row(2, 0, 5, 32'h5555_0005, 0);
        writeback_row(2, 1, 6, 32'h5555_0006, 0);
        writeback_row(0, 2, 4, 32'h5555_0004, 1);
        sync_row(0);
        dispatch_row(5, 11, 0, 1, 0, 0, 0, 0);      // Illegal instruction
        dispatch_row(5, 12, 0, 1, 0, 0, 1, 1);
        dispatch_row(5, 13, 0, 1, 0, 0, 0, 2);
        writeback_row(0, 0, 2, 32'h5555_0012, 0);
        writeback_row(0, 0, 0, 32'h5555_0010, 0);
        sync_row(5);
        dispatch_row(6, 0, 0, 0, 0, 1, 0, 0);       // mret then a normal entry
        dispatch_row(6, 14, 5, 1, 0, 0, 0, 1);
        writeback_row(0, 0, 1, 32'h6666_0001, 0);
        sync_row(6);
    endtask

    task automatic clear_drives();
        disp_valid     = 1'b0;
        disp_inst      = '0;
        disp_pc        = '0;
        disp_reg_write = 1'b0;
        disp_mem_write = 1'b0;
        disp_mret      = 1'b0;
        disp_exception = 1'b0;
        wb_valid       = '0;
        wb_tag         = '0;
        wb_value       = '0;
        wb_exc         = '0;
        br_valid       = 1'b0;
        br_tag         = '0;
        br_target      = '0;
        br_mispredict  = 1'b0;
    endtask

    // Retire in order, a trap at the head empties everything
    task automatic model_drain();
        while (m_valid[m_head] && m_ready[m_head]) begin
            exp_q.push_back(m_ent[m_head]);
            if (m_ent[m_head].kind == EV_EXC) begin
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    m_valid[i] = 1'b0;
                end
                m_head = '0;
                m_tail = '0;
            end else begin
                m_valid[m_head] = 1'b0;
                m_head++;
            end
        end
    endtask

    task automatic apply_row(row_t r);
        event_t e;
        tag_t   t;
        case (r.act)
            ACT_DISP: begin
                while (rob_full) @(negedge clk);    // Front end holds
                check_tag(disp_tag, r.chk_tag ? r.exp_tag : m_tail, "disp_tag");
                disp_valid     = 1'b1;
                disp_inst      = {17'h0, r.f3, r.rd, 7'h33};
                disp_pc        = r.pc;
                disp_reg_write = r.rw;
                disp_mem_write = r.mw;
                disp_mret      = r.mret;
                disp_exception = r.exc;
                e       = '0;
                e.kind  = r.exc ? EV_EXC : (r.mret ? EV_MRET : EV_COMMIT);
                e.tag   = m_tail;
                e.pc    = r.pc;
                e.rd    = r.rd;
                e.f3    = r.f3;
                e.rw    = r.rw;
                e.mw    = r.mw;
                e.cause = r.exc ? CAUSE_ILLEGAL : CAUSE_NONE;
                m_ent[m_tail]   = e;
                m_valid[m_tail] = 1'b1;
                m_ready[m_tail] = r.exc | r.mret;
                m_tail++;
            end
            ACT_WB: begin
                wb_valid[r.port] = 1'b1;
                wb_tag[r.port]   = r.tag;
                wb_value[r.port] = r.value;
                wb_exc[r.port]   = r.exc;
                m_ready[r.tag]       = 1'b1;
                m_ent[r.tag].value   = r.value;
                if (r.exc && r.port != 2'd0) begin  // ALU port cannot trap
                    m_ent[r.tag].kind  = EV_EXC;
                    m_ent[r.tag].cause = (r.port == 2'd1) ? CAUSE_DIV : CAUSE_LOAD;
                end
            end
            ACT_BR: begin
                br_valid      = 1'b1;
                br_tag        = r.tag;
                br_target     = r.value;
                br_mispredict = r.mispredict;
                m_ready[r.tag]     = 1'b1;
                m_ent[r.tag].value = r.value;
                if (r.mispredict) begin
                    t = r.tag + tag_t'(1);
                    while (t != m_tail) begin
                        m_valid[t] = 1'b0;
                        t++;
                    end
                    m_tail = r.tag + tag_t'(1);
                end
            end
            ACT_FULL: begin
                check_flag(rob_full, 1'b1, "rob_full");
                disp_valid = 1'b1;                  // Must be ignored
                disp_pc    = 32'hbad0_0000;
            end
            ACT_SYNC: begin
                while (exp_q.size() != 0) @(negedge clk);
                repeat (2) @(negedge clk);
                if (r.test != 8'd0) begin
                    tests_run++;
                    if (err_count != errs_at_start) begin
                        tests_failed++;
                    end
                    $display("Test %0d finished: %s", r.test,
                        (err_count != errs_at_start) ? "errors" : "ok");
                    errs_at_start = err_count;
                end
            end
            ACT_IDLE: ;
            default: ;
        endcase
        model_drain();
    endtask

    // Retire event monitor
    always @(negedge clk) begin
        if (!rst && (commit_valid || mret_sig || exception_sig)) begin
            got_kind = exception_sig ? EV_EXC : (mret_sig ? EV_MRET : EV_COMMIT);
            if (exp_q.size() == 0) begin
                $display("Retire event of kind %0d at %0t with nothing predicted",
                    got_kind, $time);
                err_count++;
            end else begin
                seen = exp_q.pop_front();
                if (got_kind != seen.kind) begin
                    $display("ERR %0t: retire kind %0d, expected %0d for tag %0d",
                        $time, got_kind, seen.kind, seen.tag);
                    err_count++;
                end else if (got_kind == EV_COMMIT) begin
                    check_commit(commit_tag, commit_pc, commit_value, commit_rd, commit_funct3,
                        commit_reg_write, commit_mem_write, seen);
                end else if (got_kind == EV_EXC) begin
                    check_exception(exception_cause, epc, commit_valid, seen);
                end else begin
                    check_mret(commit_valid, seen);
                end
            end
        end
    end

    initial begin
        int   lo;
        int   hi;
        int   j;
        row_t tmp;
        clear_drives();
        for (int i = 0; i < ROB_DEPTH; i++) begin
            m_valid[i] = 1'b0;
            m_ready[i] = 1'b0;
            m_ent[i]   = '0;
        end
        m_head = '0;
        m_tail = '0;
        void'($urandom(10738));
        build_table();
        lo = 0;
        while (lo < rows.size()) begin              // Shuffle writeback groups
            hi = lo;
            if (rows[lo].group != 8'd0) begin
                while (hi + 1 < rows.size() && rows[hi + 1].group == rows[lo].group) hi++;
            end
            for (int i = hi; i > lo; i--) begin
                j       = lo + int'($urandom % 32'(i - lo + 1));
                tmp     = rows[i];
                rows[i] = rows[j];
                rows[j] = tmp;
            end
            lo = hi + 1;
        end
        fork
            begin
                #(rows.size() * 40 * 8);
                $display("The run timed out before all table rows completed");
                $display("SIMULATION FAILED");
                $finish;
            end
        join_none
        @(negedge clk);
        while (rst) @(negedge clk);
        foreach (rows[i]) begin
            @(negedge clk);
            clear_drives();
            apply_row(rows[i]);
        end
        @(negedge clk);
        clear_drives();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
